/* build.f */
hw/egr_pkg.sv
hw/egr_tag_fifo.sv
hw/egr_tag_arb.sv
hw/egr_seg_reader.sv
hw/egr_top.sv
dv/egr_mem_model.sv
dv/egr_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the egress testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module egr_tb -f build.f -o egr_sim

# Output goes to the console and is searched for the pass line
sim_out=$(./obj_dir/egr_sim)
echo "${sim_out}"

if grep -qx "Test OK" <<< "${sim_out}"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* dv/egr_tb.sv */
// Egress block testbench
// Random tags and port back-pressure, checked against per-channel reference queues
`timescale 1ns/1ns

module egr_tb
  import egr_pkg::*;
();

  localparam int TAG_FIFO_DEPTH = 4;
  localparam int WATCHDOG_NS    = 200 * 16 * 20 * 4;
  localparam int MAIN_TAGS      = 150;
  localparam int STALL_CYCLES   = 60;
  localparam int RELEASE_LIMIT  = 2000;
  localparam int DRAIN_LIMIT    = 4000;

  logic                     egress_clock = 1'b0;
  logic                     rst;
  logic                     tag_valid0;
  logic                     tag_ready0;
  egr_tag_t                 tag0;
  logic                     tag_valid1;
  logic                     tag_ready1;
  egr_tag_t                 tag1;
  egr_wb_req_t              wb_req;
  logic                     wb_ack;
  logic [EGR_DATA_W-1:0]    wb_dat;
  logic [EGR_NUM_PORTS-1:0] tx_valid;
  logic [EGR_NUM_PORTS-1:0] tx_ready;
  egr_tx_t                  tx;
  // Memory wait states for the next request
  logic [1:0]               mem_wait;

  logic [31:0] lcg_state = 32'd51;
  int          value_errors = 0;
  int          other_errors = 0;
  int          pkt_count = 0;
  int          acc0 = 0;
  int          acc1 = 0;
  int          base0;
  int          base1;
  int          cycles;

  // Reference model state
  egr_tag_t             ref_q0[$];
  egr_tag_t             ref_q1[$];
  egr_tag_t             cur_tag;
  logic                 in_pkt = 1'b0;
  logic [3:0]           beat_idx;
  logic [EGR_ADR_W-1:0] rd_adr;
  logic [EGR_ADR_W-1:0] held_adr;
  logic                 adr_wait = 1'b0;
  logic                 hold_pend = 1'b0;
  logic [3:0]           held_valid;
  egr_tx_t              held_tx;

  egr_top #(
    .TAG_FIFO_DEPTH (TAG_FIFO_DEPTH)
  ) u_dut (
    .egress_clock (egress_clock),
    .rst          (rst),
    .tag_valid0   (tag_valid0),
    .tag_ready0   (tag_ready0),
    .tag0         (tag0),
    .tag_valid1   (tag_valid1),
    .tag_ready1   (tag_ready1),
    .tag1         (tag1),
    .wb_req       (wb_req),
    .wb_ack       (wb_ack),
    .wb_dat       (wb_dat),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .tx           (tx)
  );

  egr_mem_model u_mem (
    .egress_clock (egress_clock),
    .rst          (rst),
    .wb_req       (wb_req),
    .wait_cycles  (mem_wait),
    .wb_ack       (wb_ack),
    .wb_dat       (wb_dat)
  );

  always #2 egress_clock = ~egress_clock;

  // ============================================================
  // Helpers
  // ============================================================

  // Upper bits are the useful ones of this generator
  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic egr_tag_t rand_tag();
    logic [31:0] r;
    egr_tag_t    t;
    r = rand_next();
    t.seg_ptr = r[31:12];
    r = rand_next();
    t.len_m1 = r[31:28];
    t.port   = r[27:26];
    return t;
  endfunction

  // Word A holds A in the low half and its inverse above
  function automatic logic [EGR_DATA_W-1:0] expected_word(input logic [EGR_ADR_W-1:0] a);
    return {~{8'h00, a}, {8'h00, a}};
  endfunction

  task automatic report_mismatch(input string msg);
    value_errors++;
    $display("[FAIL] %0t ns: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    other_errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  // Offer 0 none, 1 random, 2 always; ready 0 random, 1 all low, 2 all high
  task automatic drive_cycle(input int offer_mode, input int ready_mode);
    logic [31:0] r;
    @(negedge egress_clock);
    r = rand_next();
    tag_valid0 <= (offer_mode == 2) || (offer_mode == 1 && r[31]);
    tag_valid1 <= (offer_mode == 2) || (offer_mode == 1 && r[30]);
    tag0       <= rand_tag();
    tag1       <= rand_tag();
    if (ready_mode == 0) begin
      tx_ready <= r[29:26];
    end else begin
      tx_ready <= (ready_mode == 2) ? 4'hf : 4'h0;
    end
    mem_wait <= r[25:24];
  endtask

  task automatic check_idle();
    if (tx_valid != '0) begin
      report_mismatch($sformatf("tx_valid %b after reset", tx_valid));
    end
    if (wb_req.cyc || wb_req.stb) begin
      report_mismatch("Wishbone cycle open after reset");
    end
    if (!tag_ready0 || !tag_ready1) begin
      report_mismatch("tag_ready low with empty queues");
    end
  endtask

  // ============================================================
  // Beat and bus checks
  // ============================================================

  task automatic check_beat();
    logic [1:0]           port_idx;
    logic [EGR_ADR_W-1:0] exp_adr;
    logic                 found;
    port_idx = '0;
    found    = 1'b0;
    for (int p = 0; p < EGR_NUM_PORTS; p++) begin
      if (tx_valid[p]) begin
        port_idx = 2'(p);
      end
    end
    if (tx.sop) begin
      if (in_pkt) begin
        report_mismatch("sop before the eop of the previous packet");
      end
      // Oldest tag of either channel
      if (ref_q0.size() != 0 && ref_q0[0].port == port_idx &&
          tx.data == expected_word({ref_q0[0].seg_ptr, 4'h0})) begin
        cur_tag = ref_q0.pop_front();
        found   = 1'b1;
      end else if (ref_q1.size() != 0 && ref_q1[0].port == port_idx &&
                   tx.data == expected_word({ref_q1[0].seg_ptr, 4'h0})) begin
        cur_tag = ref_q1.pop_front();
        found   = 1'b1;
      end
      in_pkt   = found;
      beat_idx = 4'h0;
      if (!found) begin
        report_mismatch($sformatf("sop on port %0d data %h fits no oldest tag",
                                  port_idx, tx.data));
      end
    end else if (!in_pkt) begin
      report_mismatch("beat outside a packet");
    end
    if (in_pkt) begin
      exp_adr = {cur_tag.seg_ptr, beat_idx};
      if (port_idx != cur_tag.port) begin
        report_mismatch($sformatf("beat on port %0d, tag port %0d", port_idx, cur_tag.port));
      end
      if (rd_adr != exp_adr) begin
        report_mismatch($sformatf("read address %h, expected %h", rd_adr, exp_adr));
      end
      if (tx.data != expected_word(exp_adr)) begin
        report_mismatch($sformatf("data %h at word %h", tx.data, exp_adr));
      end
      if (tx.sop != (beat_idx == 4'h0) || tx.eop != (beat_idx == cur_tag.len_m1)) begin
        report_mismatch($sformatf("sop %b eop %b on beat %0d of %0d",
                                  tx.sop, tx.eop, beat_idx, cur_tag.len_m1 + 5'd1));
      end
      if (beat_idx == cur_tag.len_m1) begin
        in_pkt = 1'b0;
        pkt_count++;
      end else begin
        beat_idx = beat_idx + 4'd1;
      end
    end
  endtask

  task automatic check_bus();
    if (wb_req.stb && !wb_req.cyc) begin
      report_mismatch("stb high without cyc");
    end
    if (adr_wait && wb_req.stb && wb_req.adr != held_adr) begin
      report_mismatch($sformatf("adr moved from %h to %h before ack", held_adr, wb_req.adr));
    end
    if (wb_req.cyc && wb_req.stb && wb_ack) begin
      rd_adr = wb_req.adr;
    end
    adr_wait = wb_req.stb && !wb_ack;
    held_adr = wb_req.adr;
    // Stalled beat must not move
    if (hold_pend && (tx_valid != held_valid || tx != held_tx)) begin
      report_mismatch("beat changed while stalled by tx_ready");
    end
    hold_pend  = (tx_valid & ~tx_ready) != '0;
    held_valid = tx_valid;
    held_tx    = tx;
  endtask

  // Sampled on the rising edge, inputs settled since the falling edge
  always @(posedge egress_clock) begin
    if (rst) begin
      ref_q0.delete();
      ref_q1.delete();
      in_pkt    = 1'b0;
      adr_wait  = 1'b0;
      hold_pend = 1'b0;
    end else begin
      if (tag_valid0 && tag_ready0) begin
        ref_q0.push_back(tag0);
        acc0++;
      end
      if (tag_valid1 && tag_ready1) begin
        ref_q1.push_back(tag1);
        acc1++;
      end
      if ($countones(tx_valid) > 1) begin
        report_mismatch($sformatf("tx_valid %b has more than one bit", tx_valid));
      end
      if ((tx_valid & tx_ready) != '0) begin
        check_beat();
      end
      check_bus();
    end
  end

  // ============================================================
  // Sequence
  // ============================================================

  initial begin
    rst        = 1'b1;
    tag_valid0 = 1'b0;
    tag_valid1 = 1'b0;
    tag0       = '0;
    tag1       = '0;
    tx_ready   = '0;
    mem_wait   = '0;
    repeat (2) @(posedge egress_clock);
    @(negedge egress_clock);
    rst <= 1'b0;
    repeat (4) begin
      drive_cycle(0, 2);
      check_idle();
    end
    // Random traffic
    while (acc0 + acc1 < MAIN_TAGS) begin
      drive_cycle(1, 0);
    end
    // All ports stalled, tags offered every cycle
    base0 = acc0;
    base1 = acc1;
    repeat (STALL_CYCLES) drive_cycle(2, 1);
    drive_cycle(0, 1);
    if (acc0 - base0 > TAG_FIFO_DEPTH + 1 || acc1 - base1 > TAG_FIFO_DEPTH + 1) begin
      report_mismatch($sformatf("stall took %0d and %0d tags", acc0 - base0, acc1 - base1));
    end
    if (tag_ready0 || tag_ready1) begin
      report_mismatch("tag_ready high with all ports stalled");
    end
    cycles = 0;
    while (!(tag_ready0 && tag_ready1) && cycles < RELEASE_LIMIT) begin
      drive_cycle(0, 2);
      cycles++;
    end
    if (!(tag_ready0 && tag_ready1)) begin
      report_problem("tag_ready did not return after tx_ready was released");
    end
    // Drain what is left
    cycles = 0;
    while ((ref_q0.size() != 0 || ref_q1.size() != 0 || in_pkt) && cycles < DRAIN_LIMIT) begin
      drive_cycle(0, 0);
      cycles++;
    end
    repeat (4) drive_cycle(0, 2);
    if (ref_q0.size() != 0 || ref_q1.size() != 0 || in_pkt) begin
      report_problem($sformatf("packets never delivered, %0d and %0d tags left",
                               ref_q0.size(), ref_q1.size()));
    end
    if (tx_valid != '0 || wb_req.cyc) begin
      report_problem("reader still busy after all packets were delivered");
    end
    $display("Summary: %0d value errors, %0d other errors, %0d packets, %0d tags",
             value_errors, other_errors, pkt_count, acc0 + acc1);
    if (value_errors + other_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Bound on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with the run unfinished", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

/* dv/egr_mem_model.sv */
// Wishbone slave model of the shared segment memory
// Acks after a drawn number of wait states, data derived from the word address
`timescale 1ns/1ns

module egr_mem_model
  import egr_pkg::*;
(
  input  logic                  egress_clock,
  input  logic                  rst,
  input  egr_wb_req_t           wb_req,
  input  logic [1:0]            wait_cycles,
  output logic                  wb_ack,
  output logic [EGR_DATA_W-1:0] wb_dat
);

  // Request seen, counting wait states
  logic       in_req;
  logic [1:0] wait_left;

  // Low half is the address, high half its inverse
  function automatic logic [EGR_DATA_W-1:0] mem_word(input logic [EGR_ADR_W-1:0] a);
    logic [31:0] lo;
    lo = {8'h00, a};
    return {~lo, lo};
  endfunction

  initial begin
    wb_ack = 1'b0;
    wb_dat = '0;
  end

  // Responses move on the falling edge, away from the DUT sampling edge
  always @(negedge egress_clock) begin
    if (rst) begin
      wb_ack    <= 1'b0;
      wb_dat    <= '0;
      in_req    <= 1'b0;
      wait_left <= '0;
    end else if (!(wb_req.cyc && wb_req.stb) || wb_ack) begin
      // Idle bus, or the ack was just taken
      wb_ack <= 1'b0;
      in_req <= 1'b0;
    end else if (!in_req) begin
      // New request, wait count comes from the testbench generator
      in_req <= 1'b1;
      if (wait_cycles == 2'd0) begin
        wb_ack <= 1'b1;
        wb_dat <= mem_word(wb_req.adr);
      end else begin
        wait_left <= wait_cycles - 2'd1;
      end
    end else if (wait_left == 2'd0) begin
      wb_ack <= 1'b1;
      wb_dat <= mem_word(wb_req.adr);
    end else begin
      wait_left <= wait_left - 2'd1;
    end
  end

endmodule

/* hw/egr_top.sv */
// Egress top level
// Two tag queues, round-robin arbiter and segment reader
`timescale 1ns/1ns

module egr_top
  import egr_pkg::*;
#(
  parameter int TAG_FIFO_DEPTH = 4
) (
  input  logic                     egress_clock,
  input  logic                     rst,
  input  logic                     tag_valid0,
  output logic                     tag_ready0,
  input  egr_tag_t                 tag0,
  input  logic                     tag_valid1,
  output logic                     tag_ready1,
  input  egr_tag_t                 tag1,
  output egr_wb_req_t              wb_req,
  input  logic                     wb_ack,
  input  logic [EGR_DATA_W-1:0]    wb_dat,
  output logic [EGR_NUM_PORTS-1:0] tx_valid,
  input  logic [EGR_NUM_PORTS-1:0] tx_ready,
  output egr_tx_t                  tx
);

  // Queue heads, bit i per channel
  logic [1:0] head_valid;
  egr_tag_t   head_tag0;
  egr_tag_t   head_tag1;
  logic [1:0] pop;

  // Arbiter to reader
  logic       rdr_idle;
  logic       start;
  egr_tag_t   start_tag;

  // ==========================================================
  // Tag queues
  // ==========================================================

  egr_tag_fifo #(
    .TAG_FIFO_DEPTH (TAG_FIFO_DEPTH)
  ) u_tag_fifo0 (
    .egress_clock (egress_clock),
    .rst          (rst),
    .in_valid     (tag_valid0),
    .in_ready     (tag_ready0),
    .in_tag       (tag0),
    .head_valid   (head_valid[0]),
    .head_tag     (head_tag0),
    .pop          (pop[0])
  );

  egr_tag_fifo #(
    .TAG_FIFO_DEPTH (TAG_FIFO_DEPTH)
  ) u_tag_fifo1 (
    .egress_clock (egress_clock),
    .rst          (rst),
    .in_valid     (tag_valid1),
    .in_ready     (tag_ready1),
    .in_tag       (tag1),
    .head_valid   (head_valid[1]),
    .head_tag     (head_tag1),
    .pop          (pop[1])
  );

  // ==========================================================
  // Arbiter and reader
  // ==========================================================

  egr_tag_arb u_tag_arb (
    .egress_clock (egress_clock),
    .rst          (rst),
    .head_valid   (head_valid),
    .head_tag0    (head_tag0),
    .head_tag1    (head_tag1),
    .pop          (pop),
    .rdr_idle     (rdr_idle),
    .start        (start),
    .start_tag    (start_tag)
  );

  egr_seg_reader u_seg_reader (
    .egress_clock (egress_clock),
    .rst          (rst),
    .start        (start),
    .start_tag    (start_tag),
    .idle         (rdr_idle),
    .wb_req       (wb_req),
    .wb_ack       (wb_ack),
    .wb_dat       (wb_dat),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .tx           (tx)
  );

endmodule

/* hw/egr_seg_reader.sv */
// Egress segment reader
// Reads one packet over Wishbone and drives its words to the tagged port
`timescale 1ns/1ns

module egr_seg_reader
  import egr_pkg::*;
(
  input  logic                     egress_clock,
  input  logic                     rst,
  input  logic                     start,
  input  egr_tag_t                 start_tag,
  output logic                     idle,
  output egr_wb_req_t              wb_req,
  input  logic                     wb_ack,
  input  logic [EGR_DATA_W-1:0]    wb_dat,
  output logic [EGR_NUM_PORTS-1:0] tx_valid,
  input  logic [EGR_NUM_PORTS-1:0] tx_ready,
  output egr_tx_t                  tx
);

  // ==========================================================
  // Sequencer states
  // ==========================================================

  // Waiting for a tag
  localparam logic [1:0] ST_IDLE = 2'd0;
  // Wishbone cycle open
  localparam logic [1:0] ST_READ = 2'd1;
  // Beat in the output register
  localparam logic [1:0] ST_HOLD = 2'd2;

  logic [1:0]           state;
  logic [1:0]           state_nxt;
  egr_tag_t             cur_tag;
  logic [EGR_LEN_W-1:0] word_cnt;
  logic                 rd_done;
  logic                 tx_xfer;
  logic                 last_word;

  // Ack only counts while the cycle is open
  assign rd_done   = (state == ST_READ) && wb_ack;
  // Only the addressed port is valid, so any match is the transfer
  assign tx_xfer   = (state == ST_HOLD) && ((tx_valid & tx_ready) != '0);
  assign last_word = (word_cnt == cur_tag.len_m1);

  assign idle = (state == ST_IDLE);

  // ==========================================================
  // Wishbone request
  // ==========================================================

  // cyc and stb follow the read state and drop with the ack edge
  assign wb_req.cyc = (state == ST_READ);
  assign wb_req.stb = (state == ST_READ);
  // Word index in the low bits
  assign wb_req.adr = {cur_tag.seg_ptr, word_cnt};

  // ==========================================================
  // Next state
  // ==========================================================

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_READ;
        end
      end
      ST_READ: begin
        if (rd_done) begin
          state_nxt = ST_HOLD;
        end
      end
      ST_HOLD: begin
        // Last beat out ends the packet
        if (tx_xfer) begin
          state_nxt = last_word ? ST_IDLE : ST_READ;
        end
      end
      default: state_nxt = ST_IDLE;
    endcase
  end

  // ==========================================================
  // Control registers
  // ==========================================================

  always_ff @(posedge egress_clock) begin
    if (rst) begin
      state    <= ST_IDLE;
      word_cnt <= '0;
      tx_valid <= '0;
    end else begin
      state <= state_nxt;
      // New packet starts at word 0
      if (idle && start) begin
        word_cnt <= '0;
      end else if (tx_xfer && !last_word) begin
        word_cnt <= word_cnt + 1'b1;
      end
      // Valid on the tagged port only
      if (rd_done) begin
        tx_valid               <= '0;
        tx_valid[cur_tag.port] <= 1'b1;
      end else if (tx_xfer) begin
        tx_valid <= '0;
      end
    end
  end

  // ==========================================================
  // Payload registers
  // ==========================================================

  // Tag held for the whole packet
  always_ff @(posedge egress_clock) begin
    if (idle && start) begin
      cur_tag <= start_tag;
    end
  end

  // Beat loaded on ack, held through back-pressure
  always_ff @(posedge egress_clock) begin
    if (rd_done) begin
      tx.data <= wb_dat;
      tx.sop  <= (word_cnt == '0);
      tx.eop  <= last_word;
    end
  end

endmodule

/* hw/egr_tag_arb.sv */
// Egress tag arbiter
// Round-robin between two queue heads, hands one tag at a time to the reader
`timescale 1ns/1ns

module egr_tag_arb
  import egr_pkg::*;
(
  input  logic       egress_clock,
  input  logic       rst,
  input  logic [1:0] head_valid,
  input  egr_tag_t   head_tag0,
  input  egr_tag_t   head_tag1,
  output logic [1:0] pop,
  input  logic       rdr_idle,
  output logic       start,
  output egr_tag_t   start_tag
);

  // Channel granted last time
  logic     last_grant;
  // Grant issued, reader not yet busy
  logic     pending;
  logic     grant;
  logic     pick;
  egr_tag_t pick_tag;

  // ==========================================================
  // Choice
  // ==========================================================

  // Both valid, so the other channel goes first
  always_comb begin
    if (head_valid == 2'b11) begin
      pick = ~last_grant;
    end else begin
      // Single requester or none
      pick = head_valid[1];
    end
  end

  assign pick_tag = pick ? head_tag1 : head_tag0;
  assign grant    = rdr_idle && !pending && (head_valid != 2'b00);

  // ==========================================================
  // Grant register
  // ==========================================================

  always_ff @(posedge egress_clock) begin
    if (rst) begin
      // Channel 0 preferred after reset
      last_grant <= 1'b1;
      pending    <= 1'b0;
      start      <= 1'b0;
      pop        <= 2'b00;
    end else begin
      start <= grant;
      pop   <= grant ? (2'b01 << pick) : 2'b00;
      if (grant) begin
        last_grant <= pick;
        pending    <= 1'b1;
      end else if (pending && !rdr_idle) begin
        // Reader has taken the tag
        pending <= 1'b0;
      end
    end
  end

  // Granted tag for the reader
  always_ff @(posedge egress_clock) begin
    if (grant) begin
      start_tag <= pick_tag;
    end
  end

endmodule

/* hw/egr_tag_fifo.sv */
// Egress tag queue for one channel
// Circular buffer with valid/ready push and head/pop read side
`timescale 1ns/1ns

module egr_tag_fifo
  import egr_pkg::*;
#(
  parameter int TAG_FIFO_DEPTH = 4
) (
  input  logic     egress_clock,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  egr_tag_t in_tag,
  output logic     head_valid,
  output egr_tag_t head_tag,
  input  logic     pop
);

  // Pointer and count widths
  localparam int PTR_W = (TAG_FIFO_DEPTH > 1) ? $clog2(TAG_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(TAG_FIFO_DEPTH + 1);

  egr_tag_t          mem [TAG_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop_ok;

  // Wrap at depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(TAG_FIFO_DEPTH - 1)) begin
      ptr_next = '0;
    end else begin
      ptr_next = p + 1'b1;
    end
  endfunction

  // Ready from occupancy only
  assign in_ready   = (count != CNT_W'(TAG_FIFO_DEPTH));
  assign head_valid = (count != '0);
  assign head_tag   = mem[rd_ptr];

  assign push   = in_valid && in_ready;
  // Pop on an empty queue is ignored
  assign pop_ok = pop && head_valid;

  // Tag storage
  always_ff @(posedge egress_clock) begin
    if (push) begin
      mem[wr_ptr] <= in_tag;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop_ok) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Push and pop together leave the count alone
      case ({push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hw/egr_pkg.sv */
// Egress block shared definitions
// Fixed widths, packet tag, transmit beat and Wishbone request types
package egr_pkg;

  // ==========================================================
  // Fixed sizes
  // ==========================================================

  // Transmit ports served by the reader
  localparam int EGR_NUM_PORTS = 4;

  // Segment memory word
  localparam int EGR_DATA_W = 64;

  // Wishbone word address
  localparam int EGR_ADR_W = 24;

  // Tag field widths
  localparam int EGR_PTR_W  = 20;
  localparam int EGR_LEN_W  = 4;
  localparam int EGR_PORT_W = 2;

  // ==========================================================
  // Packet tag
  // ==========================================================

  // One tag describes one packet in segment memory
  // Word k sits at {seg_ptr, k}
  typedef struct packed {
    logic [EGR_PTR_W-1:0]  seg_ptr;
    // Words minus one, 1 to 16 words
    logic [EGR_LEN_W-1:0]  len_m1;
    // Destination transmit port
    logic [EGR_PORT_W-1:0] port;
  } egr_tag_t;

  // ==========================================================
  // Transmit beat
  // ==========================================================

  // Shared by all ports, qualified by the per-port valid
  typedef struct packed {
    logic [EGR_DATA_W-1:0] data;
    // First word of the packet
    logic                  sop;
    // Last word of the packet
    logic                  eop;
  } egr_tx_t;

  // ==========================================================
  // Wishbone classic read request
  // ==========================================================

  // Read only master, so no we or sel lines
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic [EGR_ADR_W-1:0] adr;
  } egr_wb_req_t;

endpackage
